// ==== decode_unit.f ====
common/rv_decode_pkg.sv
hw/instr_fields.sv
hw/imm_gen.sv
control/control_fsm.sv
control/control_outputs.sv
hw/decode_unit.sv
testbench/tb_decode_unit.sv

// ==== Bender.yml ====
package:
  name: decode_unit

sources:
  - common/rv_decode_pkg.sv
  - hw/instr_fields.sv
  - hw/imm_gen.sv
  - control/control_fsm.sv
  - control/control_outputs.sv
  - hw/decode_unit.sv
  - target: test
    files:
      - testbench/tb_decode_unit.sv

// ==== testbench/tb_decode_unit.sv ====
// testbench for decode_unit, runs random and directed instructions and checks controls with assertions
`timescale 1ns/10ps

module tb_decode_unit;

    import rv_decode_pkg::*;

    localparam int NUM_TESTS  = 48;
    localparam int WAIT_LIMIT = 20;   // cycles before a missing fetch counts as a hang

    logic       clk;
    logic       reset;
    xlen_t      instruction;
    logic       cond_chk;
    opcode_t    opcode;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;
    funct3_t    funct3;
    funct7_t    funct7;
    xlen_t      imm;
    logic       iord;
    logic       mem_write;
    mtor_t      mtor;
    logic       ir_write;
    logic       alu_src_a;
    alu_src_b_t alu_src_b;
    alu_op_t    alu_control;
    logic       pc_src;
    logic       reg_write;
    logic       branch;
    logic       pc_write;
    logic       pc_en;

    xlen_t       words [0:NUM_TESTS];
    xlen_t       cur_word;    // word the DUT should be executing
    opcode_t     cur_op;
    int          cyc;         // cycle within the instruction, 0 is fetch
    logic [31:0] cond_seed;
    int          errors;
    int          failed_tests;
    logic        exp_reg_write;
    logic        exp_mem_write;
    logic        exp_iord;
    logic        exp_pc_write;
    logic        exp_branch;
    logic        exp_pc_en;
    alu_op_t     exp_alu;

    decode_unit dut_i (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int class_len(input opcode_t op);
        case (op)
            OP_LUI:  return 3;
            OP_LOAD: return 5;
            OP_R, OP_IMM, OP_STORE, OP_AUIPC, OP_JALR, OP_JAL, OP_BRANCH: return 4;
            default: return 2;   // unknown opcode goes straight back to fetch
        endcase
    endfunction

    function automatic xlen_t ref_imm(input xlen_t w);
        case (w[6:0])
            OP_LOAD, OP_JALR: return {{20{w[31]}}, w[31:20]};
            OP_IMM: begin
                if (w[14:12] == 3'b001 || w[14:12] == 3'b101) begin
                    return {27'b0, w[24:20]};   // shift amount
                end
                return {{20{w[31]}}, w[31:20]};
            end
            OP_STORE:         return {{20{w[31]}}, w[31:25], w[11:7]};
            OP_BRANCH:        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            OP_JAL:           return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            OP_LUI, OP_AUIPC: return {w[31:12], 12'b0};
            default:          return '0;
        endcase
    endfunction

    task automatic log_error(input string msg);
        errors++;
        $display("FAIL at %0d ns: %s", $time, msg);
    endtask

    // directed words for sub, sra, srai and slli, random ones after that
    task automatic build_words();
        logic [31:0] seed;
        opcode_t     ops [0:9];
        seed = 32'h651c;
        ops  = '{OP_R, OP_LOAD, OP_JALR, OP_IMM, OP_STORE, OP_BRANCH, OP_JAL, OP_LUI,
                 OP_AUIPC, 7'b0001111};
        words[0] = {7'b0100000, 5'd3, 5'd2, 3'b000, 5'd1, OP_R};
        words[1] = {7'b0100000, 5'd5, 5'd4, 3'b101, 5'd6, OP_R};
        words[2] = {7'b0100000, 5'd7, 5'd8, 3'b101, 5'd9, OP_IMM};
        words[3] = {7'b0000000, 5'd31, 5'd10, 3'b001, 5'd11, OP_IMM};
        for (int k = 4; k <= NUM_TESTS; k++) begin
            seed = lcg_next(seed);
            words[k] = {seed[31:7], 7'b0};
            seed = lcg_next(seed);
            words[k][6:0] = ops[(seed >> 16) % 10];
        end
    endtask

    // counts cycles from the capture edge until the next fetch
    task automatic wait_fetch(output int cycles, output logic timed_out);
        cycles    = 1;
        timed_out = 1'b0;
        @(negedge clk);
        while (!ir_write && !timed_out) begin
            if (cycles >= WAIT_LIMIT) begin
                timed_out = 1'b1;
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    // reference position in the state path, kept from the class length table
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            cyc      <= 0;
            cur_word <= '0;
        end else if (cyc == 0) begin
            cur_word <= instruction;   // fetch captures the word
            cyc      <= 1;
        end else if (cyc == class_len(cur_word[6:0]) - 1) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    always @(posedge clk) begin
        cond_seed <= lcg_next(cond_seed);
        cond_chk  <= cond_seed[16];   // random branch outcome each cycle
    end

    assign cur_op = cur_word[6:0];

    always_comb begin
        exp_reg_write = ((cur_op == OP_R || cur_op == OP_IMM || cur_op == OP_AUIPC) && cyc == 3)
                        || (cur_op == OP_LOAD && cyc == 4) || (cur_op == OP_LUI && cyc == 2)
                        || ((cur_op == OP_JAL || cur_op == OP_JALR) && cyc == 2);
        exp_mem_write = (cur_op == OP_STORE) && cyc == 3;
        exp_iord      = (cur_op == OP_STORE || cur_op == OP_LOAD) && cyc == 3;
        exp_pc_write  = (cyc == 0) || ((cur_op == OP_JAL || cur_op == OP_JALR) && cyc == 3);
        exp_branch    = (cur_op == OP_BRANCH) && (cyc == 2 || cyc == 3);
        exp_pc_en     = exp_pc_write || (exp_branch && cond_chk);
        case (cur_op)
            OP_R:    exp_alu = {cur_word[30], cur_word[14:12]};
            OP_IMM:  exp_alu = {(cur_word[14:12] == 3'b101) & cur_word[30], cur_word[14:12]};
            default: exp_alu = {1'b1, cur_word[14:12]};   // branch compare
        endcase
    end

    a_reset_outputs: assert property (@(posedge clk) reset |-> ir_write && pc_write && pc_en
        && !mem_write && !reg_write && !branch && !iord)
        else log_error("control outputs wrong during reset");
    a_fields: assert property (@(posedge clk) disable iff (reset)
        opcode == cur_word[6:0] && rd == cur_word[11:7] && funct3 == cur_word[14:12]
        && rs1 == cur_word[19:15] && rs2 == cur_word[24:20] && funct7 == cur_word[31:25])
        else log_error("register fields differ from the fetched word");
    a_imm: assert property (@(posedge clk) disable iff (reset)
        (cyc != 1) |-> imm == ref_imm(cur_word))
        else log_error($sformatf("imm %h, expected %h", imm, ref_imm(cur_word)));
    a_ir_write: assert property (@(posedge clk) disable iff (reset) ir_write == (cyc == 0))
        else log_error("ir_write out of step with the class length");
    a_writes: assert property (@(posedge clk) disable iff (reset)
        reg_write == exp_reg_write && mem_write == exp_mem_write && iord == exp_iord)
        else log_error($sformatf("write enables wrong in cycle %0d of opcode %b", cyc, cur_op));
    a_pc: assert property (@(posedge clk) disable iff (reset)
        pc_write == exp_pc_write && branch == exp_branch && pc_en == exp_pc_en)
        else log_error($sformatf("pc controls wrong in cycle %0d of opcode %b", cyc, cur_op));
    a_alu: assert property (@(posedge clk) disable iff (reset)
        (cyc == 2 && (cur_op == OP_R || cur_op == OP_IMM || cur_op == OP_BRANCH))
        |-> alu_control == exp_alu)
        else log_error($sformatf("alu_control %b, expected %b", alu_control, exp_alu));
    // pc + 4 at fetch, rs1 with rs2 or the immediate in execute and address cycles
    a_src: assert property (@(posedge clk) disable iff (reset)
        ((cyc == 0) |-> !alu_src_a && alu_src_b == SRCB_FOUR && !pc_src)
        and ((cyc == 2 && (cur_op == OP_R || cur_op == OP_IMM || cur_op == OP_LOAD
              || cur_op == OP_STORE))
             |-> alu_src_a && alu_src_b == ((cur_op == OP_R) ? SRCB_REG : SRCB_IMM))
        and ((cyc == 2 && cur_op == OP_BRANCH) |-> pc_src))
        else log_error($sformatf("operand selects wrong in cycle %0d of opcode %b", cyc, cur_op));
    a_mtor: assert property (@(posedge clk) disable iff (reset)
        ((cyc == 2 && cur_op == OP_LUI) |-> mtor == MTOR_IMM)
        and ((cyc == 4 && cur_op == OP_LOAD) |-> mtor == MTOR_MEM))
        else log_error($sformatf("mtor %b wrong in writeback", mtor));

    initial begin
        int   cycles;
        int   errs_before;
        logic timed_out;
        reset        <= 1'b1;
        instruction  = '0;
        cond_chk     = 1'b0;
        cond_seed    = 32'h651c;
        errors       = 0;
        failed_tests = 0;
        build_words();
        repeat (5) @(posedge clk);
        reset       <= 1'b0;
        instruction <= words[0];
        @(negedge clk);   // first fetch after reset
        for (int i = 0; i < NUM_TESTS; i++) begin
            errs_before = errors;
            @(posedge clk);   // words[i] captured here
            instruction <= words[i + 1];
            wait_fetch(cycles, timed_out);
            if (timed_out) begin
                $display("timeout: no instruction fetch within %0d cycles", WAIT_LIMIT);
                errors++;
                failed_tests++;
                break;
            end
            a_length: assert (cycles == class_len(words[i][6:0]))
                else log_error($sformatf("%0d cycles seen, %0d expected",
                                         cycles, class_len(words[i][6:0])));
            if (errors != errs_before) begin
                failed_tests++;
            end
            $display("test %0d opcode %b: %0d cycles, %s", i, words[i][6:0], cycles,
                     (errors == errs_before) ? "ok" : "failed");
        end
        $display("%0d tests run, %0d failed, %0d check errors", NUM_TESTS, failed_tests, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/decode_unit.sv ====
// top level of the multicycle rv32i control path, joining instruction register, immediate and FSM
`timescale 1ns/10ps

module decode_unit (
    input  logic                      clk,
    input  logic                      reset,
    input  rv_decode_pkg::xlen_t      instruction,
    input  logic                      cond_chk,       // branch compare result
    output rv_decode_pkg::opcode_t    opcode,
    output rv_decode_pkg::reg_addr_t  rs1,
    output rv_decode_pkg::reg_addr_t  rs2,
    output rv_decode_pkg::reg_addr_t  rd,
    output rv_decode_pkg::funct3_t    funct3,
    output rv_decode_pkg::funct7_t    funct7,
    output rv_decode_pkg::xlen_t      imm,
    output logic                      iord,
    output logic                      mem_write,
    output rv_decode_pkg::mtor_t      mtor,
    output logic                      ir_write,
    output logic                      alu_src_a,
    output rv_decode_pkg::alu_src_b_t alu_src_b,
    output rv_decode_pkg::alu_op_t    alu_control,
    output logic                      pc_src,
    output logic                      reg_write,
    output logic                      branch,
    output logic                      pc_write,
    output logic                      pc_en
);

    import rv_decode_pkg::*;

    stage_t stage;     // current fsm state
    xlen_t  ir_word;   // held instruction for the immediate

    instr_fields instr_fields_i (
        .clk         (clk),
        .reset       (reset),
        .ir_write    (ir_write),
        .instruction (instruction),
        .ir_word     (ir_word),
        .opcode      (opcode),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .funct3      (funct3),
        .funct7      (funct7)
    );

    imm_gen imm_gen_i (
        .clk     (clk),
        .reset   (reset),
        .stage   (stage),
        .ir_word (ir_word),
        .opcode  (opcode),
        .funct3  (funct3),
        .imm     (imm)
    );

    control_fsm control_fsm_i (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .stage  (stage)
    );

    control_outputs control_outputs_i (
        .stage       (stage),
        .funct3      (funct3),
        .funct7      (funct7),
        .cond_chk    (cond_chk),
        .iord        (iord),
        .mem_write   (mem_write),
        .ir_write    (ir_write),
        .alu_src_a   (alu_src_a),
        .pc_src      (pc_src),
        .reg_write   (reg_write),
        .branch      (branch),
        .pc_write    (pc_write),
        .pc_en       (pc_en),
        .mtor        (mtor),
        .alu_src_b   (alu_src_b),
        .alu_control (alu_control)
    );

endmodule

// ==== control/control_outputs.sv ====
// moore decode of the current stage into datapath selects, write enables and alu operation
`timescale 1ns/10ps

module control_outputs (
    input  rv_decode_pkg::stage_t     stage,
    input  rv_decode_pkg::funct3_t    funct3,
    input  rv_decode_pkg::funct7_t    funct7,
    input  logic                      cond_chk,
    output logic                      iord,
    output logic                      mem_write,
    output logic                      ir_write,
    output logic                      alu_src_a,
    output logic                      pc_src,
    output logic                      reg_write,
    output logic                      branch,
    output logic                      pc_write,
    output logic                      pc_en,
    output rv_decode_pkg::mtor_t      mtor,
    output rv_decode_pkg::alu_src_b_t alu_src_b,
    output rv_decode_pkg::alu_op_t    alu_control
);

    import rv_decode_pkg::*;

    logic sra_bit;   // funct7[5] only matters for srai among op-imm

    assign sra_bit = (funct3 == 3'b101) ? funct7[5] : 1'b0;

    always_comb begin
        iord        = 1'b0;
        mem_write   = 1'b0;
        ir_write    = 1'b0;
        alu_src_a   = 1'b0;   // 0 selects pc, 1 selects rs1
        pc_src      = 1'b0;   // 0 selects alu result, 1 selects alu out
        reg_write   = 1'b0;
        branch      = 1'b0;
        pc_write    = 1'b0;
        mtor        = MTOR_ALU;
        alu_src_b   = SRCB_REG;
        alu_control = '0;
        case (stage)
            ST_FETCH: begin
                ir_write    = 1'b1;
                pc_write    = 1'b1;
                alu_src_b   = SRCB_FOUR;   // pc + 4
                alu_control = ALU_ADD;
            end
            ST_DECODE: begin
                alu_src_b = SRCB_IMM;   // speculative branch target
            end
            ST_EXEC_R: begin
                alu_src_a   = 1'b1;
                alu_control = {funct7[5], funct3};   // sub and sra set bit 3
            end
            ST_EXEC_I: begin
                alu_src_a   = 1'b1;
                alu_src_b   = SRCB_IMM;
                alu_control = {sra_bit, funct3};
            end
            ST_ALU_WB: begin
                reg_write = 1'b1;
            end
            ST_LOAD_ADDR, ST_STORE_ADDR: begin
                alu_src_a   = 1'b1;
                alu_src_b   = SRCB_IMM;
                alu_control = ALU_ADD;   // rs1 + offset
            end
            ST_MEM_READ: begin
                iord = 1'b1;
            end
            ST_MEM_WB: begin
                mtor      = MTOR_MEM;
                reg_write = 1'b1;
            end
            ST_MEM_WRITE: begin
                iord      = 1'b1;
                mem_write = 1'b1;
            end
            ST_LUI_WB: begin
                mtor      = MTOR_IMM;
                reg_write = 1'b1;
            end
            ST_AUIPC_EXEC: begin
                alu_src_b   = SRCB_IMM;
                alu_control = ALU_ADD;   // pc + upper immediate
            end
            ST_JALR_WB, ST_JAL_WB: begin
                pc_src      = 1'b1;
                reg_write   = 1'b1;   // link address into rd
                alu_control = ALU_ADD;
            end
            ST_JALR_PC: begin
                alu_src_a   = 1'b1;
                alu_src_b   = SRCB_IMM;
                alu_control = ALU_ADD;
                pc_write    = 1'b1;
            end
            ST_JAL_PC: begin
                alu_src_b   = SRCB_IMM;
                alu_control = ALU_ADD;
                pc_write    = 1'b1;
            end
            ST_BR_CHECK: begin
                alu_src_a   = 1'b1;
                alu_src_b   = SRCB_IMM;
                alu_control = {1'b1, funct3};   // compare code
                pc_src      = 1'b1;
                branch      = 1'b1;
            end
            ST_BR_UPDATE: begin
                branch = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign pc_en = pc_write | (branch & cond_chk);

    // a store and a register write in one state would corrupt the datapath
    always_comb begin
        a_no_mem_and_reg_write: assert final (!(mem_write && reg_write))
            else $error("mem_write and reg_write high in the same stage");
    end

endmodule

// ==== control/control_fsm.sv ====
// multicycle stage sequencer, steps each instruction class through its path back to fetch
`timescale 1ns/10ps

module control_fsm (
    input  logic                   clk,
    input  logic                   reset,
    input  rv_decode_pkg::opcode_t opcode,
    output rv_decode_pkg::stage_t  stage
);

    import rv_decode_pkg::*;

    stage_t stage_q;
    stage_t stage_next;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stage_q <= ST_FETCH;
        end else begin
            stage_q <= stage_next;
        end
    end

    assign stage = stage_q;

    always_comb begin
        stage_next = ST_FETCH;
        case (stage_q)
            ST_FETCH:  stage_next = ST_DECODE;
            ST_DECODE: begin
                // opcode is already the new instruction here
                case (opcode)
                    OP_R:      stage_next = ST_EXEC_R;
                    OP_LOAD:   stage_next = ST_LOAD_ADDR;
                    OP_IMM:    stage_next = ST_EXEC_I;
                    OP_STORE:  stage_next = ST_STORE_ADDR;
                    OP_LUI:    stage_next = ST_LUI_WB;
                    OP_AUIPC:  stage_next = ST_AUIPC_EXEC;
                    OP_JALR:   stage_next = ST_JALR_WB;
                    OP_JAL:    stage_next = ST_JAL_WB;
                    OP_BRANCH: stage_next = ST_BR_CHECK;
                    default:   stage_next = ST_FETCH;   // unknown opcode is dropped
                endcase
            end

            // r-type, op-imm and auipc share the alu writeback
            ST_EXEC_R:     stage_next = ST_ALU_WB;
            ST_EXEC_I:     stage_next = ST_ALU_WB;
            ST_AUIPC_EXEC: stage_next = ST_ALU_WB;
            ST_ALU_WB:     stage_next = ST_FETCH;

            ST_LOAD_ADDR:  stage_next = ST_MEM_READ;
            ST_MEM_READ:   stage_next = ST_MEM_WB;
            ST_MEM_WB:     stage_next = ST_FETCH;

            ST_STORE_ADDR: stage_next = ST_MEM_WRITE;
            ST_MEM_WRITE:  stage_next = ST_FETCH;

            ST_LUI_WB:     stage_next = ST_FETCH;

            ST_JALR_WB:    stage_next = ST_JALR_PC;
            ST_JALR_PC:    stage_next = ST_FETCH;
            ST_JAL_WB:     stage_next = ST_JAL_PC;
            ST_JAL_PC:     stage_next = ST_FETCH;

            ST_BR_CHECK:   stage_next = ST_BR_UPDATE;
            ST_BR_UPDATE:  stage_next = ST_FETCH;

            default:       stage_next = ST_FETCH;   // recover from a bad encoding
        endcase
    end

    a_stage_legal: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(stage_q) && (stage_q <= ST_BR_UPDATE)
    ) else $error("stage register left the legal encoding range");

    // the longest path (load) needs four cycles after decode
    a_back_to_fetch: assert property (
        @(posedge clk) disable iff (reset)
        (stage_q == ST_DECODE) |-> ##[1:4] (stage_q == ST_FETCH)
    ) else $error("instruction did not return to fetch in time");

endmodule

// ==== hw/imm_gen.sv ====
// immediate generator that builds and holds the 32-bit immediate during decode
`timescale 1ns/10ps

module imm_gen (
    input  logic                   clk,
    input  logic                   reset,
    input  rv_decode_pkg::stage_t  stage,
    input  rv_decode_pkg::xlen_t   ir_word,
    input  rv_decode_pkg::opcode_t opcode,
    input  rv_decode_pkg::funct3_t funct3,
    output rv_decode_pkg::xlen_t   imm
);

    import rv_decode_pkg::*;

    xlen_t imm_i;
    xlen_t imm_s;
    xlen_t imm_b;
    xlen_t imm_j;
    xlen_t imm_u;
    xlen_t imm_shamt;
    xlen_t imm_next;

    // one candidate per format
    assign imm_i     = {{20{ir_word[31]}}, ir_word[31:20]};
    assign imm_s     = {{20{ir_word[31]}}, ir_word[31:25], ir_word[11:7]};
    assign imm_b     = {{19{ir_word[31]}}, ir_word[31], ir_word[7],
                        ir_word[30:25], ir_word[11:8], 1'b0};
    assign imm_j     = {{11{ir_word[31]}}, ir_word[31], ir_word[19:12],
                        ir_word[20], ir_word[30:21], 1'b0};
    assign imm_u     = {ir_word[31:12], 12'b0};
    assign imm_shamt = {27'b0, ir_word[24:20]};   // slli, srli, srai

    always_comb begin
        case (opcode)
            OP_LOAD, OP_JALR: imm_next = imm_i;
            OP_IMM: begin
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    imm_next = imm_shamt;
                end else begin
                    imm_next = imm_i;
                end
            end
            OP_STORE:         imm_next = imm_s;
            OP_BRANCH:        imm_next = imm_b;
            OP_JAL:           imm_next = imm_j;
            OP_LUI, OP_AUIPC: imm_next = imm_u;
            default:          imm_next = '0;   // r-type and unknown
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            imm <= '0;
        end else if (stage == ST_DECODE) begin
            imm <= imm_next;   // held until the next decode
        end
    end

endmodule

// ==== hw/instr_fields.sv ====
// instruction register, loaded in fetch, that presents the rv32i fields of the held word
`timescale 1ns/10ps

module instr_fields (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    ir_write,
    input  rv_decode_pkg::xlen_t    instruction,
    output rv_decode_pkg::xlen_t    ir_word,
    output rv_decode_pkg::opcode_t  opcode,
    output rv_decode_pkg::reg_addr_t rs1,
    output rv_decode_pkg::reg_addr_t rs2,
    output rv_decode_pkg::reg_addr_t rd,
    output rv_decode_pkg::funct3_t  funct3,
    output rv_decode_pkg::funct7_t  funct7
);

    import rv_decode_pkg::*;

    xlen_t ir_q;   // held instruction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ir_q <= '0;
        end else if (ir_write) begin
            ir_q <= instruction;   // captured at end of fetch
        end
    end

    assign ir_word = ir_q;

    // standard rv32i field positions
    assign opcode = ir_q[6:0];
    assign rd     = ir_q[11:7];
    assign funct3 = ir_q[14:12];
    assign rs1    = ir_q[19:15];
    assign rs2    = ir_q[24:20];
    assign funct7 = ir_q[31:25];

    // a fetch from a driven memory must leave a clean word for decode
    a_ir_known: assert property (
        @(posedge clk) disable iff (reset)
        ir_write |=> !$isunknown(ir_word)
    ) else $error("instruction register holds unknown bits after fetch");

endmodule

// ==== common/rv_decode_pkg.sv ====
// shared opcodes, field types, control encodings and FSM states for the RV32I decode unit
package rv_decode_pkg;

    localparam int XLEN       = 32;
    localparam int OPCODE_W   = 7;
    localparam int REG_ADDR_W = 5;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;
    localparam int ALU_OP_W   = 4;

    typedef logic [XLEN-1:0]       xlen_t;     // instruction and immediate word
    typedef logic [OPCODE_W-1:0]   opcode_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [FUNCT3_W-1:0]   funct3_t;
    typedef logic [FUNCT7_W-1:0]   funct7_t;
    typedef logic [ALU_OP_W-1:0]   alu_op_t;   // {variant bit, funct3}
    typedef logic [1:0]            mtor_t;     // writeback source select
    typedef logic [1:0]            alu_src_b_t;

    // major opcodes
    localparam opcode_t OP_R      = 7'b0110011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;

    localparam mtor_t MTOR_ALU = 2'b00;   // alu result register
    localparam mtor_t MTOR_MEM = 2'b01;   // memory read data
    localparam mtor_t MTOR_IMM = 2'b10;   // immediate, for lui

    localparam alu_src_b_t SRCB_REG  = 2'b00;
    localparam alu_src_b_t SRCB_FOUR = 2'b01;   // pc increment
    localparam alu_src_b_t SRCB_IMM  = 2'b10;

    localparam alu_op_t ALU_ADD = 4'b0000;

    // multicycle stages, numbered as in the older single-block decoder
    typedef enum logic [4:0] {
        ST_FETCH      = 5'd0,
        ST_DECODE     = 5'd1,
        ST_EXEC_R     = 5'd2,
        ST_ALU_WB     = 5'd3,
        ST_LOAD_ADDR  = 5'd4,
        ST_MEM_READ   = 5'd5,
        ST_MEM_WB     = 5'd6,
        ST_EXEC_I     = 5'd7,
        ST_STORE_ADDR = 5'd8,
        ST_MEM_WRITE  = 5'd9,
        ST_LUI_WB     = 5'd10,
        ST_AUIPC_EXEC = 5'd11,
        ST_JALR_WB    = 5'd12,
        ST_JALR_PC    = 5'd13,
        ST_JAL_WB     = 5'd14,
        ST_JAL_PC     = 5'd15,
        ST_BR_CHECK   = 5'd16,
        ST_BR_UPDATE  = 5'd17
    } stage_t;

endpackage
